// File: dv/tremolo_stim.txt
// columns: enable, input sample, expected output (all hex, one row per sample)
// depth starts at 0 and steps once per row with enable set, 0 up to 16 and back
// full sweep with a constant upper half sample
1 c8 37
1 c8 40
1 c8 49
1 c8 52
1 c8 5b
1 c8 64
1 c8 6d
1 c8 76
1 c8 7f
1 c8 88
1 c8 91
1 c8 9a
1 c8 a3
1 c8 ac
1 c8 b5
1 c8 be
1 c8 c7
1 c8 be
1 c8 b5
1 c8 ac
1 c8 a3
1 c8 9a
1 c8 91
1 c8 88
1 c8 7f
1 c8 76
1 c8 6d
1 c8 64
1 c8 5b
1 c8 52
1 c8 49
1 c8 40
1 c8 37
// lower half samples while depth climbs from 1 to 16
1 00 0f
1 7f 7f
1 64 6e
1 40 5f
1 01 4f
1 7e 7e
1 20 73
1 7f 7f
1 5a 83
1 11 9a
1 32 9b
1 78 82
1 03 cc
1 4b a6
1 6e 8d
1 00 fe
// bypass with the depth held at 15
0 00 00
0 7f 7f
0 80 80
0 ff ff
// resume falling from 15 down to 0
1 80 7f
1 ff de
1 7f 7f
1 96 8a
1 0a aa
1 f0 9b
1 81 7f
1 3c 7f
1 b4 78
1 14 64
1 fe 4f
1 c8 5b
1 28 48
1 e6 32
1 80 7f
1 ff 00
// climb again from 1 to 16
1 82 7d
1 05 23
1 d2 4b
1 7f 7f
1 80 7f
1 63 78
1 a0 7b
1 ff 7f
1 00 8e
1 be 8e
1 46 94
1 8c 85
1 19 be
1 f5 d6
1 55 a3
1 ff fe

// File: tremolo.f
source/tremolo_pkg.sv
source/tremolo_if.sv
source/tremolo_ctrl.sv
source/triangle_lfo.sv
source/tremolo_gain.sv
source/tremolo_top.sv
dv/tremolo_assert.sv
dv/tremolo_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := tremolo_tb
FILELIST   := tremolo.f
BUILD_DIR  := obj_dir
SIM_BIN    := $(BUILD_DIR)/V$(TOP)
LOG        := sim.log
FAIL_MSG   := TB FAILED

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log is searched for the failure line, a crash or assertion stop also fails
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tremolo_tb.sv
`timescale 1ns/10ps

module tremolo_tb
    import tremolo_pkg::*;
;

    localparam int num_rows      = 85;  // rows in the stimulus file
    localparam int valid_timeout = 64;  // cycles allowed while waiting for one sample
    localparam int valid_period  = 8;   // clocks from one valid pulse to the next
    localparam int reset_cycles  = 16;

    logic                clk = 1'b0;
    logic                rst;
    logic                en;
    logic [sample_w-1:0] audio_in;
    logic [sample_w-1:0] audio_out;
    logic                sample_valid;

    logic [7:0] stim_mem [0:3*num_rows-1];  // enable, sample and expected output per row

    tremolo_top uut (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .audio_in     (audio_in),
        .audio_out    (audio_out),
        .sample_valid (sample_valid)
    );

    always #4 clk = ~clk;  // 8 ns period

    // compare one value and stop at the first mismatch
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // read the rows and make sure every field is usable
    task automatic load_stimulus();
        $readmemh("dv/tremolo_stim.txt", stim_mem);
        for (int i = 0; i < 3 * num_rows; i++) begin
            if ($isunknown(stim_mem[i])) begin
                $display("stimulus file has no valid data at word %0d", i);
                $display("TB FAILED");
                $fatal(1, "incomplete stimulus file");
            end else if ((i % 3 == 0) && (stim_mem[i] > 8'd1)) begin
                $display("stimulus row %0d has an enable field other than 0 or 1", i / 3);
                $display("TB FAILED");
                $fatal(1, "bad enable field in stimulus file");
            end
        end
    endtask

    // outputs are looked at on the falling edge where they are settled
    task automatic wait_for_valid(input int row, output int cycles);
        logic found;
        found  = 1'b0;
        cycles = 0;
        while (!found) begin
            @(negedge clk);
            cycles++;
            if (sample_valid === 1'b1) begin
                found = 1'b1;
            end else if (cycles >= valid_timeout) begin
                $display("sample_valid never came within %0d cycles on row %0d",
                         valid_timeout, row);
                $display("TB FAILED");
                $fatal(1, "timeout waiting for sample_valid");
            end
        end
    endtask

    // one sample per row, driven right after the previous valid pulse
    task automatic run_row(input int row);
        logic [7:0] en_val;
        logic [7:0] smp_in;
        logic [7:0] expected;
        int         cycles;
        en_val   = stim_mem[3*row];
        smp_in   = stim_mem[3*row + 1];
        expected = stim_mem[3*row + 2];
        @(posedge clk);
        en       <= en_val[0];
        audio_in <= smp_in;
        wait_for_valid(row, cycles);
        if (row > 0) begin
            // the first row starts from reset and has a shorter wait
            check_value($sformatf("row %0d valid spacing", row), valid_period, cycles);
        end
        check_value($sformatf("row %0d en %0d in %0d", row, en_val[0], smp_in),
                    expected, audio_out);
    endtask

    initial begin
        rst      = 1'b1;
        en       = 1'b0;
        audio_in = '0;
        load_stimulus();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("audio_out after reset", 0, audio_out);
        check_value("sample_valid after reset", 0, sample_valid);
        for (int row = 0; row < num_rows; row++) begin
            run_row(row);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: dv/tremolo_assert.sv
`timescale 1ns/10ps

module tremolo_assert
    import tremolo_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic               tick,
    input logic               active,
    input logic [depth_w-1:0] depth,
    input logic               sample_valid
);

    int unsigned since_tick;  // clocks since the last tick, zero before the first one

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            since_tick <= 0;
        end else if (tick) begin
            since_tick <= 1;
        end else if (since_tick != 0) begin
            since_tick <= since_tick + 1;
        end
    end

    // ticks come exactly 2 * tick_half clocks apart, so never two in a row
    tick_period: assert property (@(posedge clk) disable iff (rst)
        (since_tick != 0) |-> (tick == (since_tick == 2 * tick_half)))
        else $error("tick did not come exactly every %0d clocks", 2 * tick_half);

    depth_range: assert property (@(posedge clk) disable iff (rst)
        depth <= depth_w'(depth_max))
        else $error("depth went above its peak value");

    // an enabled tick moves the triangle one step up or down
    depth_step: assert property (@(posedge clk) disable iff (rst)
        (tick && active) |=>
            ((depth == $past(depth) + 1'b1) || (depth == $past(depth) - 1'b1)))
        else $error("depth did not move by one after an enabled tick");

    depth_hold: assert property (@(posedge clk) disable iff (rst)
        !(tick && active) |=> $stable(depth))
        else $error("depth changed without an enabled tick");

    valid_after_tick: assert property (@(posedge clk) disable iff (rst)
        sample_valid == $past(tick))
        else $error("sample_valid does not follow tick by one cycle");

endmodule

bind tremolo_top tremolo_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .tick         (bus.tick),
    .active       (bus.active),
    .depth        (bus.depth),
    .sample_valid (sample_valid)
);

// File: source/tremolo_top.sv
`timescale 1ns/10ps

module tremolo_top
    import tremolo_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                en,            // tremolo on when high, bypass when low
    input  logic [sample_w-1:0] audio_in,      // held stable until sample_valid
    output logic [sample_w-1:0] audio_out,
    output logic                sample_valid   // one cycle pulse per sample period
);

    // tick, enable and depth shared between the three stages
    tremolo_if bus ();

    // sample rate timing and enable register
    tremolo_ctrl u_ctrl (
        .clk (clk),
        .rst (rst),
        .en  (en),
        .bus (bus.ctrl)
    );

    // triangle depth oscillator
    triangle_lfo u_lfo (
        .clk (clk),
        .rst (rst),
        .bus (bus.lfo)
    );

    // sample decode, mix and output register
    tremolo_gain u_gain (
        .clk          (clk),
        .rst          (rst),
        .audio_in     (audio_in),
        .bus          (bus.gain),
        .audio_out    (audio_out),
        .sample_valid (sample_valid)
    );

endmodule

// File: source/tremolo_gain.sv
`timescale 1ns/10ps

module tremolo_gain
    import tremolo_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [sample_w-1:0] audio_in,
    tremolo_if.gain             bus,
    output logic [sample_w-1:0] audio_out,
    output logic                sample_valid
);

    sample_u             smp;     // input word with both views
    logic [mix_w-1:0]    base;    // mirrored sample that the depth swings away from
    logic [mix_w-1:0]    span;    // distance from the sample to the midpoint
    logic [mix_w-1:0]    d_wide;  // depth widened for the product
    logic [mix_w-1:0]    scaled;  // depth weighted share of the span
    logic [mix_w-1:0]    mix;     // full width tremolo result
    logic [sample_w-1:0] result;  // value loaded into the output register

    assign smp    = audio_in;
    assign d_wide = mix_w'(bus.depth);

    // the half flag picks the formula, the offset gives the distance to the midpoint
    always_comb begin
        if (smp.half.upper) begin
            base = mix_w'(sample_max) - mix_w'(smp.raw);  // 255 - x
            span = mix_w'(smp.half.offset);               // x - 128
        end else begin
            base = mix_w'(smp.raw);                       // x itself
            span = mix_w'(half_max) - mix_w'(smp.half.offset);  // 127 - x
        end
    end

    // at depth 0 the sample is mirrored, at depth_max it moves to the far side
    assign scaled = (mix_w'(2) * span * d_wide) / mix_w'(depth_max);
    assign mix    = base + scaled;

    // the largest result is 254, so the low byte holds it exactly
    // with the effect off the sample goes straight through
    assign result = bus.active ? mix[sample_w-1:0] : smp.raw;

    // one result per tick, flagged in the following cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            audio_out    <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= bus.tick;
            if (bus.tick) begin
                audio_out <= result;  // uses the depth from before this tick
            end
        end
    end

endmodule

// File: source/triangle_lfo.sv
`timescale 1ns/10ps

module triangle_lfo
    import tremolo_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    tremolo_if.lfo bus
);

    logic [depth_w-1:0] depth_nxt;   // depth after the next enabled tick
    logic               rising_nxt;  // direction after the next enabled tick
    logic               step;        // advance the triangle this cycle

    // the triangle only moves on ticks while the effect is enabled
    assign step = bus.tick & bus.active;

    // walk 0 up to depth_max and back down, turning at both ends
    always_comb begin
        depth_nxt  = bus.depth;
        rising_nxt = bus.rising;
        if (bus.rising && (bus.depth < depth_w'(depth_max))) begin
            depth_nxt = bus.depth + 1'b1;
        end else if (bus.depth == depth_w'(depth_max)) begin
            depth_nxt  = bus.depth - 1'b1;  // turn at the peak
            rising_nxt = 1'b0;
        end else if (!bus.rising && (bus.depth != '0)) begin
            depth_nxt = bus.depth - 1'b1;
        end else begin
            depth_nxt  = bus.depth + 1'b1;  // turn at zero
            rising_nxt = 1'b1;
        end
    end

    // with active low the triangle simply holds where it stopped
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bus.depth  <= '0;
            bus.rising <= 1'b1;
        end else if (step) begin
            bus.depth  <= depth_nxt;
            bus.rising <= rising_nxt;
        end
    end

endmodule

// File: source/tremolo_ctrl.sv
`timescale 1ns/10ps

module tremolo_ctrl
    import tremolo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    en,
    tremolo_if.ctrl bus
);

    logic [div_w-1:0] div_cnt;    // clock count within one half period
    logic             div_last;   // final count of a half period
    logic             clk_div;    // divided sample clock
    logic             clk_div_q;  // divided clock one cycle late

    // the divided clock toggles once every tick_half system clocks
    assign div_last = (div_cnt == div_w'(tick_half - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            clk_div <= 1'b0;
        end else if (div_last) begin
            div_cnt <= '0;
            clk_div <= ~clk_div;  // half period complete
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // past copy of the divided clock for edge detection
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            clk_div_q <= 1'b0;
        end else begin
            clk_div_q <= clk_div;
        end
    end

    // rising edge of the divided clock gives one tick every 2 * tick_half clocks
    assign bus.tick = clk_div & ~clk_div_q;

    // the enable is sampled once per clock so it stays steady around a tick
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bus.active <= 1'b0;
        end else begin
            bus.active <= en;  // one register of delay from the pin
        end
    end

endmodule

// File: source/tremolo_if.sv
`timescale 1ns/10ps

interface tremolo_if
    import tremolo_pkg::*;
;

    logic               tick;    // one cycle pulse at the start of each sample period
    logic               active;  // registered enable level
    logic [depth_w-1:0] depth;   // current triangle value
    logic               rising;  // triangle direction, set while climbing

    // control owns sample timing and the enable
    modport ctrl (
        output tick,
        output active
    );

    // oscillator steps the triangle on enabled ticks
    modport lfo (
        input  tick,
        input  active,
        output depth,
        output rising
    );

    // gain stage mixes the sample with the current depth
    modport gain (
        input tick,
        input active,
        input depth
    );

endinterface

// File: source/tremolo_pkg.sv
package tremolo_pkg;

    // audio sample format, offset binary around the midpoint
    localparam int sample_w   = 8;
    localparam int sample_mid = 128;                  // first code of the upper half
    localparam int sample_max = (1 << sample_w) - 1;  // full scale code, 255
    localparam int half_max   = sample_mid - 1;       // last code of the lower half, 127

    // triangle depth range
    localparam int depth_max = 16;                    // peak of the triangle and the mix divisor
    localparam int depth_w   = 5;                     // wide enough to hold depth_max

    // sample rate divider
    localparam int tick_half = 4;                     // clocks per half period of the divided clock
    localparam int div_w     = $clog2(tick_half);     // width of the divider counter

    // intermediate width for the mixing arithmetic
    localparam int mix_w = 2 * sample_w;              // holds 2 * 127 * 16 with room to spare

    // one sample word seen either as a plain byte or as a half flag plus offset
    typedef struct packed {
        logic                upper;   // set for codes 128 to 255
        logic [sample_w-2:0] offset;  // position within the selected half
    } sample_half_t;

    typedef union packed {
        logic [sample_w-1:0] raw;     // byte as it arrived on the input
        sample_half_t        half;    // decoded view used by the mixer
    } sample_u;

endpackage
